/* Bender.yml */
package:
  name: inverse_engine

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/inverse_pkg.sv
      - logic/matrix_store.sv
      - logic/pivot_swapper.sv
      - logic/row_eliminator.sv
      - logic/row_normalizer.sv
      - logic/gauss_jordan_ctrl.sv
      - logic/inverse_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clock.sv
      - testbench/inverse_chk.sv
      - testbench/inverse_tb.sv

/* include/inverse_settings.svh */
`ifndef INVERSE_SETTINGS_SVH
`define INVERSE_SETTINGS_SVH

// matrix geometry
`define INV_N 5
`define INV_COLS (2 * `INV_N)

// Q16.16 words
`define INV_W 32
`define INV_FRAC 16
`define INV_ONE (32'sh0001_0000)

// 5 x 10 words need 6 address bits
`define INV_AW 6

`endif

/* logic/gauss_jordan_ctrl.sv */
`timescale 1ns/1ns
`include "inverse_settings.svh"

module gauss_jordan_ctrl
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic busy,
	output logic done,
	output logic singular,
	output inverse_pkg::col_t col,
	output logic swap_go,
	output logic elim_go,
	output logic norm_go,
	input  logic swap_fin,
	input  logic swap_nofound,
	input  logic elim_fin,
	input  logic norm_fin,
	output logic init_req,
	output logic init_we,
	output inverse_pkg::addr_t init_addr,
	output inverse_pkg::fix_t init_wdata,
	input  logic init_gnt
);

	typedef enum logic [2:0]
	{
		C_IDLE,
		C_INIT,
		C_SWAP,
		C_ELIM,
		C_NORM
	} state_t;

	state_t state;
	inverse_pkg::row_t ir;
	inverse_pkg::col_t ic;

	// identity fill of the right half
	assign init_req = (state == C_INIT);
	assign init_we = init_req;
	assign init_addr = inverse_pkg::elem_addr(ir, inverse_pkg::col_t'(`INV_N) + ic);
	assign init_wdata = (ic == inverse_pkg::col_t'(ir)) ? `INV_ONE : '0;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= C_IDLE;
			busy <= 1'b0;
			done <= 1'b0;
			singular <= 1'b0;
			col <= '0;
			swap_go <= 1'b0;
			elim_go <= 1'b0;
			norm_go <= 1'b0;
			ir <= '0;
			ic <= '0;
		end
		else
		begin
			swap_go <= 1'b0;
			elim_go <= 1'b0;
			norm_go <= 1'b0;
			done <= 1'b0;
			if (done)
				busy <= 1'b0;
			case (state)
				C_IDLE:
					if (start)
					begin
						busy <= 1'b1;
						singular <= 1'b0;
						ir <= '0;
						ic <= '0;
						state <= C_INIT;
					end
				C_INIT:
					if (init_gnt)
					begin
						if (ic == `INV_N - 1)
						begin
							ic <= '0;
							if (ir == `INV_N - 1)
							begin
								col <= '0;
								swap_go <= 1'b1;
								state <= C_SWAP;
							end
							else
								ir <= ir + 1'b1;
						end
						else
							ic <= ic + 1'b1;
					end
				C_SWAP:
					if (swap_nofound)
					begin
						singular <= 1'b1; // no usable pivot in this column
						done <= 1'b1;
						state <= C_IDLE;
					end
					else if (swap_fin)
					begin
						elim_go <= 1'b1;
						state <= C_ELIM;
					end
				C_ELIM:
					if (elim_fin)
					begin
						if (col == `INV_N - 1)
						begin
							norm_go <= 1'b1;
							state <= C_NORM;
						end
						else
						begin
							col <= col + 1'b1;
							swap_go <= 1'b1;
							state <= C_SWAP;
						end
					end
				C_NORM:
					if (norm_fin)
					begin
						done <= 1'b1;
						state <= C_IDLE;
					end
				default:
					state <= C_IDLE;
			endcase
		end
	end

endmodule

/* logic/inverse_pkg.sv */
`include "inverse_settings.svh"

package inverse_pkg;

	// signed Q16.16 element
	typedef logic signed [`INV_W-1:0] fix_t;

	// products and quotients before truncation
	typedef logic signed [2*`INV_W-1:0] wide_t;

	typedef logic [2:0] row_t;
	typedef logic [3:0] col_t;
	typedef logic [`INV_AW-1:0] addr_t;

	// store slots below the host, in priority order
	typedef enum logic [1:0]
	{
		PEER_SWAP,
		PEER_ELIM,
		PEER_NORM
	} peer_t;

	// row-major position in the augmented array
	function automatic addr_t elem_addr(input row_t r, input col_t c);
		return addr_t'(r * `INV_COLS + c);
	endfunction

endpackage

/* logic/inverse_top.sv */
`timescale 1ns/1ns
`include "inverse_settings.svh"

module inverse_top
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic wr_strobe,
	input  inverse_pkg::row_t wr_row,
	input  inverse_pkg::col_t wr_col,
	input  inverse_pkg::fix_t wr_data,
	input  logic rd_strobe,
	input  inverse_pkg::row_t rd_row,
	input  inverse_pkg::col_t rd_col,
	output inverse_pkg::fix_t rd_data,
	output logic rd_valid,
	output logic busy,
	output logic done,
	output logic singular
);

	logic wr_ok;
	logic host_req;
	logic host_we;
	inverse_pkg::addr_t host_addr;

	logic [inverse_pkg::PEER_NORM:inverse_pkg::PEER_SWAP] eng_req;
	logic [inverse_pkg::PEER_NORM:inverse_pkg::PEER_SWAP] eng_we;
	logic [inverse_pkg::PEER_NORM:inverse_pkg::PEER_SWAP] eng_gnt;
	inverse_pkg::addr_t eng_addr [inverse_pkg::PEER_SWAP:inverse_pkg::PEER_NORM];
	inverse_pkg::fix_t eng_wdata [inverse_pkg::PEER_SWAP:inverse_pkg::PEER_NORM];

	inverse_pkg::col_t col;
	logic swap_go;
	logic elim_go;
	logic norm_go;
	logic swap_fin;
	logic swap_nofound;
	logic elim_fin;
	logic norm_fin;

	logic init_req;
	logic init_we;
	inverse_pkg::addr_t init_addr;
	inverse_pkg::fix_t init_wdata;
	logic sw_req;
	logic sw_we;
	inverse_pkg::addr_t sw_addr;
	inverse_pkg::fix_t sw_wdata;

	////////////////////////////////////////
	// host port

	assign wr_ok = wr_strobe & ~busy & (wr_col < `INV_N); // left half, idle only
	assign host_req = rd_strobe | wr_ok;
	assign host_we = wr_ok & ~rd_strobe;
	assign host_addr = rd_strobe ? inverse_pkg::elem_addr(rd_row, rd_col)
		: inverse_pkg::elem_addr(wr_row, wr_col);

	// identity fill and swapper never run together
	assign eng_req[inverse_pkg::PEER_SWAP] = init_req | sw_req;
	assign eng_we[inverse_pkg::PEER_SWAP] = init_req ? init_we : sw_we;
	assign eng_addr[inverse_pkg::PEER_SWAP] = init_req ? init_addr : sw_addr;
	assign eng_wdata[inverse_pkg::PEER_SWAP] = init_req ? init_wdata : sw_wdata;

	matrix_store u_store
	(
		.clk(clk),
		.rst(rst),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(wr_data),
		.req(eng_req),
		.we(eng_we),
		.addr(eng_addr),
		.wdata(eng_wdata),
		.gnt(eng_gnt),
		.rdata(rd_data),
		.host_rvalid(rd_valid)
	);

	gauss_jordan_ctrl u_ctrl
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.done(done),
		.singular(singular),
		.col(col),
		.swap_go(swap_go),
		.elim_go(elim_go),
		.norm_go(norm_go),
		.swap_fin(swap_fin),
		.swap_nofound(swap_nofound),
		.elim_fin(elim_fin),
		.norm_fin(norm_fin),
		.init_req(init_req),
		.init_we(init_we),
		.init_addr(init_addr),
		.init_wdata(init_wdata),
		.init_gnt(eng_gnt[inverse_pkg::PEER_SWAP])
	);

	pivot_swapper u_swap
	(
		.clk(clk),
		.rst(rst),
		.go(swap_go),
		.col(col),
		.fin(swap_fin),
		.nofound(swap_nofound),
		.req(sw_req),
		.we(sw_we),
		.addr(sw_addr),
		.wdata(sw_wdata),
		.gnt(eng_gnt[inverse_pkg::PEER_SWAP]),
		.rdata(rd_data)
	);

	row_eliminator u_elim
	(
		.clk(clk),
		.rst(rst),
		.go(elim_go),
		.col(col),
		.fin(elim_fin),
		.req(eng_req[inverse_pkg::PEER_ELIM]),
		.we(eng_we[inverse_pkg::PEER_ELIM]),
		.addr(eng_addr[inverse_pkg::PEER_ELIM]),
		.wdata(eng_wdata[inverse_pkg::PEER_ELIM]),
		.gnt(eng_gnt[inverse_pkg::PEER_ELIM]),
		.rdata(rd_data)
	);

	row_normalizer u_norm
	(
		.clk(clk),
		.rst(rst),
		.go(norm_go),
		.fin(norm_fin),
		.req(eng_req[inverse_pkg::PEER_NORM]),
		.we(eng_we[inverse_pkg::PEER_NORM]),
		.addr(eng_addr[inverse_pkg::PEER_NORM]),
		.wdata(eng_wdata[inverse_pkg::PEER_NORM]),
		.gnt(eng_gnt[inverse_pkg::PEER_NORM]),
		.rdata(rd_data)
	);

endmodule

/* logic/matrix_store.sv */
`timescale 1ns/1ns
`include "inverse_settings.svh"

module matrix_store
(
	input  logic clk,
	input  logic rst,

	input  logic host_req,
	input  logic host_we,
	input  inverse_pkg::addr_t host_addr,
	input  inverse_pkg::fix_t host_wdata,

	input  logic [inverse_pkg::PEER_NORM:inverse_pkg::PEER_SWAP] req,
	input  logic [inverse_pkg::PEER_NORM:inverse_pkg::PEER_SWAP] we,
	input  inverse_pkg::addr_t addr [inverse_pkg::PEER_SWAP:inverse_pkg::PEER_NORM],
	input  inverse_pkg::fix_t wdata [inverse_pkg::PEER_SWAP:inverse_pkg::PEER_NORM],
	output logic [inverse_pkg::PEER_NORM:inverse_pkg::PEER_SWAP] gnt,

	output inverse_pkg::fix_t rdata,
	output logic host_rvalid
);

	localparam int DEPTH = `INV_N * `INV_COLS;

	inverse_pkg::fix_t mem [DEPTH];
	inverse_pkg::peer_t sel;
	logic eng_req;

	////////////////////////////////////////
	// arbiter

	always_comb
	begin
		if (req[inverse_pkg::PEER_SWAP])
			sel = inverse_pkg::PEER_SWAP;
		else if (req[inverse_pkg::PEER_ELIM])
			sel = inverse_pkg::PEER_ELIM;
		else
			sel = inverse_pkg::PEER_NORM;
		eng_req = |req;
		gnt = '0;
		if (!host_req && eng_req)
			gnt[sel] = 1'b1; // host steals the cycle
	end

	////////////////////////////////////////
	// storage

	always_ff @(posedge clk)
	begin
		if (host_req)
		begin
			if (host_we)
				mem[host_addr] <= host_wdata;
			else
				rdata <= mem[host_addr];
		end
		else if (eng_req)
		begin
			if (we[sel])
				mem[addr[sel]] <= wdata[sel];
			else
				rdata <= mem[addr[sel]];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			host_rvalid <= 1'b0;
		else
			host_rvalid <= host_req & ~host_we;
	end

endmodule

/* logic/pivot_swapper.sv */
`timescale 1ns/1ns
`include "inverse_settings.svh"

module pivot_swapper
(
	input  logic clk,
	input  logic rst,
	input  logic go,
	input  inverse_pkg::col_t col,
	output logic fin,
	output logic nofound,
	output logic req,
	output logic we,
	output inverse_pkg::addr_t addr,
	output inverse_pkg::fix_t wdata,
	input  logic gnt,
	input  inverse_pkg::fix_t rdata
);

	typedef enum logic [2:0]
	{
		S_IDLE,
		S_RD,
		S_CHK,
		S_RD_A,
		S_CAP_A,
		S_RD_B,
		S_WR_A,
		S_WR_B
	} state_t;

	state_t state;
	inverse_pkg::col_t col_q;
	inverse_pkg::row_t prow;
	inverse_pkg::row_t srow; // candidate row
	inverse_pkg::col_t k;
	inverse_pkg::fix_t hold;

	assign prow = inverse_pkg::row_t'(col_q);

	always_comb
	begin
		req = 1'b0;
		we = 1'b0;
		addr = inverse_pkg::elem_addr(srow, col_q);
		wdata = rdata;
		case (state)
			S_RD:
				req = 1'b1;
			S_RD_A:
			begin
				req = 1'b1;
				addr = inverse_pkg::elem_addr(prow, k);
			end
			S_RD_B:
			begin
				req = 1'b1;
				addr = inverse_pkg::elem_addr(srow, k);
			end
			S_WR_A:
			begin
				req = 1'b1;
				we = 1'b1;
				addr = inverse_pkg::elem_addr(prow, k); // lower word straight from rdata
			end
			S_WR_B:
			begin
				req = 1'b1;
				we = 1'b1;
				addr = inverse_pkg::elem_addr(srow, k);
				wdata = hold;
			end
			default:
				req = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			fin <= 1'b0;
			nofound <= 1'b0;
			col_q <= '0;
			srow <= '0;
			k <= '0;
		end
		else
		begin
			fin <= 1'b0;
			nofound <= 1'b0;
			case (state)
				S_IDLE:
					if (go)
					begin
						col_q <= col;
						srow <= inverse_pkg::row_t'(col);
						state <= S_RD;
					end
				S_RD:
					if (gnt)
						state <= S_CHK;
				S_CHK:
					if (rdata != '0)
					begin
						if (srow == prow)
						begin
							fin <= 1'b1; // pivot already usable
							state <= S_IDLE;
						end
						else
						begin
							k <= '0;
							state <= S_RD_A;
						end
					end
					else if (srow == `INV_N - 1)
					begin
						nofound <= 1'b1;
						state <= S_IDLE;
					end
					else
					begin
						srow <= srow + 1'b1;
						state <= S_RD;
					end
				S_RD_A:
					if (gnt)
						state <= S_CAP_A;
				S_CAP_A:
					state <= S_RD_B;
				S_RD_B:
					if (gnt)
						state <= S_WR_A;
				S_WR_A:
					state <= gnt ? S_WR_B : S_RD_B; // lost the slot, read again
				S_WR_B:
					if (gnt)
					begin
						if (k == `INV_COLS - 1)
						begin
							fin <= 1'b1;
							state <= S_IDLE;
						end
						else
						begin
							k <= k + 1'b1;
							state <= S_RD_A;
						end
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == S_CAP_A)
			hold <= rdata;
	end

endmodule

/* logic/row_eliminator.sv */
`timescale 1ns/1ns
`include "inverse_settings.svh"

module row_eliminator
(
	input  logic clk,
	input  logic rst,
	input  logic go,
	input  inverse_pkg::col_t col,
	output logic fin,
	output logic req,
	output logic we,
	output inverse_pkg::addr_t addr,
	output inverse_pkg::fix_t wdata,
	input  logic gnt,
	input  inverse_pkg::fix_t rdata
);

	typedef enum logic [2:0]
	{
		E_IDLE,
		E_RD_P,
		E_CAP_P,
		E_RD_F,
		E_CAP_F,
		E_RD_E,
		E_WR_E,
		E_WR_Z
	} state_t;

	state_t state;
	inverse_pkg::col_t c;
	inverse_pkg::col_t k;
	inverse_pkg::row_t row;
	inverse_pkg::row_t prow;
	inverse_pkg::row_t nrow;
	logic last_row;
	inverse_pkg::fix_t piv [`INV_COLS]; // pivot row copy
	inverse_pkg::fix_t factor;
	inverse_pkg::wide_t quot;
	inverse_pkg::wide_t prod;

	assign prow = inverse_pkg::row_t'(c);

	// next row to clear, skipping the pivot row
	always_comb
	begin
		nrow = row + 1'b1;
		if (nrow == prow)
			nrow = nrow + 1'b1;
	end

	assign last_row = (nrow >= `INV_N);

	////////////////////////////////////////
	// arithmetic

	assign quot = (inverse_pkg::wide_t'(rdata) <<< `INV_FRAC) / inverse_pkg::wide_t'(piv[c]);
	assign prod = (inverse_pkg::wide_t'(factor) * inverse_pkg::wide_t'(piv[k])) >>> `INV_FRAC;

	always_comb
	begin
		req = 1'b0;
		we = 1'b0;
		addr = inverse_pkg::elem_addr(row, k);
		wdata = rdata - inverse_pkg::fix_t'(prod);
		case (state)
			E_RD_P:
			begin
				req = 1'b1;
				addr = inverse_pkg::elem_addr(prow, k);
			end
			E_RD_F:
			begin
				req = 1'b1;
				addr = inverse_pkg::elem_addr(row, c);
			end
			E_RD_E:
				req = 1'b1;
			E_WR_E:
			begin
				req = 1'b1;
				we = 1'b1;
			end
			E_WR_Z:
			begin
				req = 1'b1;
				we = 1'b1;
				addr = inverse_pkg::elem_addr(row, c);
				wdata = '0;
			end
			default:
				req = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// sequencing

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= E_IDLE;
			fin <= 1'b0;
			c <= '0;
			k <= '0;
			row <= '0;
		end
		else
		begin
			fin <= 1'b0;
			case (state)
				E_IDLE:
					if (go)
					begin
						c <= col;
						k <= '0;
						state <= E_RD_P;
					end
				E_RD_P:
					if (gnt)
						state <= E_CAP_P;
				E_CAP_P:
					if (k == `INV_COLS - 1)
					begin
						row <= (c == '0) ? 3'd1 : 3'd0;
						state <= E_RD_F;
					end
					else
					begin
						k <= k + 1'b1;
						state <= E_RD_P;
					end
				E_RD_F:
					if (gnt)
						state <= E_CAP_F;
				E_CAP_F:
				begin
					k <= c + 1'b1; // columns left of c are already clear
					state <= E_RD_E;
				end
				E_RD_E:
					if (gnt)
						state <= E_WR_E;
				E_WR_E:
					if (!gnt)
						state <= E_RD_E;
					else if (k == `INV_COLS - 1)
						state <= E_WR_Z;
					else
					begin
						k <= k + 1'b1;
						state <= E_RD_E;
					end
				E_WR_Z:
					if (gnt)
					begin
						if (last_row)
						begin
							fin <= 1'b1;
							state <= E_IDLE;
						end
						else
						begin
							row <= nrow;
							state <= E_RD_F;
						end
					end
				default:
					state <= E_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == E_CAP_P)
			piv[k] <= rdata;
		if (state == E_CAP_F)
			factor <= inverse_pkg::fix_t'(quot);
	end

endmodule

/* logic/row_normalizer.sv */
`timescale 1ns/1ns
`include "inverse_settings.svh"

module row_normalizer
(
	input  logic clk,
	input  logic rst,
	input  logic go,
	output logic fin,
	output logic req,
	output logic we,
	output inverse_pkg::addr_t addr,
	output inverse_pkg::fix_t wdata,
	input  logic gnt,
	input  inverse_pkg::fix_t rdata
);

	typedef enum logic [2:0]
	{
		N_IDLE,
		N_RD_D,
		N_CAP_D,
		N_RD_E,
		N_WR_E,
		N_WR_D
	} state_t;

	state_t state;
	inverse_pkg::row_t row;
	inverse_pkg::col_t k;
	inverse_pkg::fix_t diag;
	inverse_pkg::wide_t quot;

	// signed, truncating toward zero
	assign quot = (inverse_pkg::wide_t'(rdata) <<< `INV_FRAC) / inverse_pkg::wide_t'(diag);

	always_comb
	begin
		req = 1'b0;
		we = 1'b0;
		addr = inverse_pkg::elem_addr(row, k);
		wdata = inverse_pkg::fix_t'(quot);
		case (state)
			N_RD_D:
			begin
				req = 1'b1;
				addr = inverse_pkg::elem_addr(row, inverse_pkg::col_t'(row));
			end
			N_RD_E:
				req = 1'b1;
			N_WR_E:
			begin
				req = 1'b1;
				we = 1'b1;
			end
			N_WR_D:
			begin
				req = 1'b1;
				we = 1'b1;
				addr = inverse_pkg::elem_addr(row, inverse_pkg::col_t'(row));
				wdata = `INV_ONE;
			end
			default:
				req = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= N_IDLE;
			fin <= 1'b0;
			row <= '0;
			k <= '0;
		end
		else
		begin
			fin <= 1'b0;
			case (state)
				N_IDLE:
					if (go)
					begin
						row <= '0;
						state <= N_RD_D;
					end
				N_RD_D:
					if (gnt)
						state <= N_CAP_D;
				N_CAP_D:
				begin
					k <= `INV_N; // right half only
					state <= N_RD_E;
				end
				N_RD_E:
					if (gnt)
						state <= N_WR_E;
				N_WR_E:
					if (!gnt)
						state <= N_RD_E;
					else if (k == `INV_COLS - 1)
						state <= N_WR_D;
					else
					begin
						k <= k + 1'b1;
						state <= N_RD_E;
					end
				N_WR_D:
					if (gnt)
					begin
						if (row == `INV_N - 1)
						begin
							fin <= 1'b1;
							state <= N_IDLE;
						end
						else
						begin
							row <= row + 1'b1;
							state <= N_RD_D;
						end
					end
				default:
					state <= N_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == N_CAP_D)
			diag <= rdata;
	end

endmodule

/* project.f */
+incdir+include
logic/inverse_pkg.sv
logic/matrix_store.sv
logic/pivot_swapper.sv
logic/row_eliminator.sv
logic/row_normalizer.sv
logic/gauss_jordan_ctrl.sv
logic/inverse_top.sv
testbench/tb_clock.sv
testbench/inverse_chk.sv
testbench/inverse_tb.sv

/* testbench/inverse_chk.sv */
`timescale 1ns/1ns

module inverse_chk
(
	input logic clk,
	input logic rst,
	input logic rd_strobe,
	input logic rd_valid,
	input logic busy,
	input logic done,
	input logic [inverse_pkg::PEER_NORM:inverse_pkg::PEER_SWAP] gnt
);

	int unsigned fails = 0;

	////////////////////////////////////////
	// store and host port

	a_one_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
	else
	begin
		fails++;
		$error("more than one engine grant in a cycle");
	end

	a_read_valid: assert property (@(posedge clk) disable iff (rst) rd_valid == $past(rd_strobe))
	else
	begin
		fails++;
		$error("rd_valid does not follow rd_strobe by one cycle");
	end

	////////////////////////////////////////
	// status

	a_done_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
	else
	begin
		fails++;
		$error("done raised while not busy");
	end

	a_reset_idle: assert property (@(posedge clk) rst |=> !busy)
	else
	begin
		fails++;
		$error("busy high after reset");
	end

endmodule

/* testbench/inverse_tb.sv */
`timescale 1ns/1ns
`include "inverse_settings.svh"

module inverse_tb;

	localparam int N = `INV_N;
	localparam int TIMEOUT = 5000; // cycles per inversion

	logic clk;
	logic rst;
	logic start;
	logic wr_strobe;
	inverse_pkg::row_t wr_row;
	inverse_pkg::col_t wr_col;
	inverse_pkg::fix_t wr_data;
	logic rd_strobe;
	inverse_pkg::row_t rd_row;
	inverse_pkg::col_t rd_col;
	inverse_pkg::fix_t rd_data;
	logic rd_valid;
	logic busy;
	logic done;
	logic singular;

	int mismatches;
	int failures;
	int total;

	inverse_pkg::fix_t mat_in [N][N];
	inverse_pkg::fix_t mat_exp [N][N];

	tb_clock u_clk
	(
		.clk(clk)
	);

	inverse_top DUT
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.wr_strobe(wr_strobe),
		.wr_row(wr_row),
		.wr_col(wr_col),
		.wr_data(wr_data),
		.rd_strobe(rd_strobe),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.busy(busy),
		.done(done),
		.singular(singular)
	);

	bind inverse_top inverse_chk u_chk
	(
		.clk(clk),
		.rst(rst),
		.rd_strobe(rd_strobe),
		.rd_valid(rd_valid),
		.busy(busy),
		.done(done),
		.gnt(eng_gnt)
	);

	////////////////////////////////////////
	// compare tasks

	task automatic check_fix(input string name, input inverse_pkg::fix_t exp,
		input inverse_pkg::fix_t act);
		if (act !== exp)
		begin
			mismatches++;
			$display("MISMATCH %s expected %0d (0x%08h) actual %0d (0x%08h)",
				name, exp, exp, act, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			mismatches++;
			$display("MISMATCH %s expected %b actual %b", name, exp, act);
		end
	endtask

	////////////////////////////////////////
	// host port

	task automatic write_elem(input int r, input int c, input inverse_pkg::fix_t d);
		wr_strobe = 1'b1;
		wr_row = inverse_pkg::row_t'(r);
		wr_col = inverse_pkg::col_t'(c);
		wr_data = d;
		@(negedge clk);
		wr_strobe = 1'b0;
	endtask

	task automatic read_elem(input string name, input int r, input int c,
		output inverse_pkg::fix_t val);
		rd_strobe = 1'b1;
		rd_row = inverse_pkg::row_t'(r);
		rd_col = inverse_pkg::col_t'(c);
		@(negedge clk);
		rd_strobe = 1'b0;
		check_flag({name, " rd_valid"}, 1'b1, rd_valid); // fixed one-cycle latency
		val = rd_data;
	endtask

	task automatic load_matrix();
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				write_elem(r, c, mat_in[r][c]);
	endtask

	task automatic run_inverse(input string name, input logic exp_sing, input logic disturb);
		int cycles;
		start = 1'b1;
		check_flag({name, " busy before start"}, 1'b0, busy);
		@(negedge clk);
		start = 1'b0;
		check_flag({name, " busy after start"}, 1'b1, busy);
		check_flag({name, " singular after start"}, 1'b0, singular);
		if (disturb)
		begin
			// would break the result if any landed
			write_elem(0, 0, '0);
			write_elem(1, 1, '0);
			write_elem(3, 4, 32'sh7fff_0000);
		end
		cycles = 0;
		while (done !== 1'b1 && cycles < TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (done !== 1'b1)
		begin
			failures++;
			$display("%s: done did not arrive within %0d cycles", name, TIMEOUT);
		end
		check_flag({name, " singular at done"}, exp_sing, singular);
		check_flag({name, " busy at done"}, 1'b1, busy);
		@(negedge clk);
		check_flag({name, " done width"}, 1'b0, done);
		check_flag({name, " busy after done"}, 1'b0, busy);
		check_flag({name, " singular held"}, exp_sing, singular); // sticky
	endtask

	task automatic check_result(input string name);
		inverse_pkg::fix_t v;
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
			begin
				read_elem(name, r, N + c, v);
				check_fix($sformatf("%s inv[%0d][%0d]", name, r, c), mat_exp[r][c], v);
			end
	endtask

	////////////////////////////////////////
	// reference matrices

	task automatic clear_mats();
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
			begin
				mat_in[r][c] = '0;
				mat_exp[r][c] = '0;
			end
	endtask

	task automatic set_identity();
		clear_mats();
		for (int i = 0; i < N; i++)
		begin
			mat_in[i][i] = `INV_ONE;
			mat_exp[i][i] = `INV_ONE;
		end
	endtask

	// solves U X = I from the bottom row up, in Q16.16
	task automatic back_substitute();
		inverse_pkg::wide_t acc;
		for (int j = 0; j < N; j++)
			for (int i = N - 1; i >= 0; i--)
			begin
				acc = (i == j) ? inverse_pkg::wide_t'(`INV_ONE) : '0;
				for (int k = i + 1; k < N; k++)
					acc = acc - ((inverse_pkg::wide_t'(mat_in[i][k])
						* inverse_pkg::wide_t'(mat_exp[k][j])) >>> `INV_FRAC);
				mat_exp[i][j] = inverse_pkg::fix_t'((acc <<< `INV_FRAC)
					/ inverse_pkg::wide_t'(mat_in[i][i]));
			end
	endtask

	////////////////////////////////////////
	// directed tests

	task automatic test_identity();
		set_identity();
		load_matrix();
		run_inverse("identity", 1'b0, 1'b0);
		check_result("identity");
	endtask

	task automatic test_diagonal();
		int k;
		clear_mats();
		for (int i = 0; i < N; i++)
		begin
			k = $urandom % 4;
			mat_in[i][i] = `INV_ONE <<< k;
			mat_exp[i][i] = `INV_ONE >>> k;
		end
		load_matrix();
		run_inverse("diagonal", 1'b0, 1'b0);
		check_result("diagonal");
	endtask

	task automatic test_permutation();
		int perm [N] = '{3, 0, 4, 1, 2}; // no fixed point, early columns need swaps
		clear_mats();
		for (int i = 0; i < N; i++)
		begin
			mat_in[i][perm[i]] = `INV_ONE;
			mat_exp[perm[i]][i] = `INV_ONE; // transpose
		end
		load_matrix();
		run_inverse("permutation", 1'b0, 1'b0);
		check_result("permutation");
	endtask

	task automatic set_upper();
		clear_mats();
		for (int i = 0; i < N; i++)
		begin
			mat_in[i][i] = `INV_ONE;
			if (i < N - 1)
				mat_in[i][i + 1] = 2 * `INV_ONE;
		end
		back_substitute();
	endtask

	task automatic test_upper();
		set_upper();
		load_matrix();
		run_inverse("upper", 1'b0, 1'b0);
		check_result("upper");
	endtask

	task automatic test_singular();
		set_identity();
		mat_in[2][2] = '0; // column 2 all zero
		load_matrix();
		run_inverse("singular", 1'b1, 1'b0);
		set_identity();
		load_matrix();
		run_inverse("after singular", 1'b0, 1'b0);
		check_result("after singular");
	endtask

	task automatic test_host_port();
		inverse_pkg::fix_t v;
		write_elem(2, 3, 32'sh0003_8000);
		read_elem("host write", 2, 3, v);
		check_fix("host write", 32'sh0003_8000, v);
		// right half is not host-writable
		read_elem("right half", 2, N + 2, v);
		check_fix("right half before", mat_exp[2][2], v); // last computed inverse
		write_elem(2, N + 2, 32'sh0000_1234);
		read_elem("right half", 2, N + 2, v);
		check_fix("right half", mat_exp[2][2], v);
		set_upper();
		load_matrix();
		run_inverse("busy writes", 1'b0, 1'b1);
		check_result("busy writes");
		read_elem("left half", 1, 1, v);
		check_fix("left half diag", `INV_ONE, v);
		read_elem("left half", 0, 1, v);
		check_fix("left half off-diag", '0, v);
	endtask

	////////////////////////////////////////
	// main sequence

	initial
	begin
		void'($urandom(58234));
		mismatches = 0;
		failures = 0;
		rst = 1'b1;
		start = 1'b0;
		wr_strobe = 1'b0;
		wr_row = '0;
		wr_col = '0;
		wr_data = '0;
		rd_strobe = 1'b0;
		rd_row = '0;
		rd_col = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_flag("reset busy", 1'b0, busy);
		check_flag("reset done", 1'b0, done);
		check_flag("reset singular", 1'b0, singular);
		check_flag("reset rd_valid", 1'b0, rd_valid);

		test_identity();
		test_diagonal();
		test_permutation();
		test_upper();
		test_singular();
		test_host_port();

		total = mismatches + failures + DUT.u_chk.fails;
		$display("errors: %0d (mismatches %0d, other %0d, assertions %0d)",
			total, mismatches, failures, DUT.u_chk.fails);
		if (total == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock
#(
	parameter int PERIOD = 8
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk; // 8 ns period
	end

endmodule
